//--- design/mipsPkg.sv
package mipsPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // ------------------------------------------------------------------
    // Instruction encodings
    // ------------------------------------------------------------------
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        functSll  = 6'h00,
        functAddu = 6'h21,
        functSubu = 6'h23,
        functAnd  = 6'h24,
        functOr   = 6'h25,
        functSlt  = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOpT;

    typedef struct packed {
        opcodeT      opcode;
        regAddrT     rs;
        regAddrT     rt;
        regAddrT     rd;
        logic [4:0]  shamt;
        functT       funct;
    } rFieldsT;

    typedef struct packed {
        opcodeT      opcode;
        regAddrT     rs;
        regAddrT     rt;
        logic [15:0] imm;
    } iFieldsT;

    // Same fetched word seen as R-type or I-type
    typedef union packed {
        rFieldsT r;
        iFieldsT i;
    } instrT;

    typedef enum logic [1:0] {
        fwdReg,
        fwdExMem,
        fwdMemWb
    } fwdSelT;

    // ------------------------------------------------------------------
    // Pipeline registers and ports
    // ------------------------------------------------------------------
    typedef struct packed {
        instrT instr;
        wordT  pc;
        logic  valid;
    } ifIdT;

    typedef struct packed {
        logic       valid;
        wordT       pc;
        regAddrT    rs;
        regAddrT    rt;
        regAddrT    dest;
        wordT       opA;
        wordT       opB;
        wordT       imm;
        logic [4:0] shamt;
        aluOpT      aluOp;
        logic       useImm;
        logic       regWrite;
        logic       memRead;
        logic       memWrite;
        logic       isBranch;
        logic       branchOnEqual;
        wordT       branchOffset;
    } idExT;

    typedef struct packed {
        logic    valid;
        wordT    aluResult;
        wordT    storeData;
        regAddrT dest;
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branchTaken;
        wordT    branchTarget;
    } exMemT;

    typedef struct packed {
        regAddrT dest;
        logic    regWrite;
        wordT    result;
    } memWbT;

    typedef struct packed {
        wordT address;
        wordT writeData;
        logic read;
        logic write;
    } dataReqT;

    typedef struct packed {
        logic   stall;
        logic   flush;
        fwdSelT fwdA;
        fwdSelT fwdB;
    } hazardCtrlT;

endpackage

//--- design/fetchStage.sv
`timescale 1ns/1ns

module fetchStage #(
    parameter mipsPkg::wordT RESET_PC = 32'h0000_0000
) (
    input  logic                CLK,
    input  logic                rstN,
    input  mipsPkg::hazardCtrlT ctrl,
    input  logic                redirect,
    input  mipsPkg::wordT       redirectPc,
    input  mipsPkg::instrT      instrIn,
    output mipsPkg::wordT       instrAddr,
    output mipsPkg::ifIdT       ifId
);

    mipsPkg::wordT pc;

    // Instruction memory answers in the same cycle
    assign instrAddr = pc;

    // Branch redirect wins over a load-use hold
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= RESET_PC;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!ctrl.stall) begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID
    always_ff @(posedge CLK) begin
        if (!rstN || ctrl.flush) begin
            ifId.valid <= 1'b0;
        end else if (!ctrl.stall) begin
            ifId.instr <= instrIn;
            ifId.pc    <= pc;
            ifId.valid <= 1'b1;
        end
    end

endmodule

//--- design/decodeStage.sv
`timescale 1ns/1ns

module decodeStage (
    input  logic                CLK,
    input  logic                rstN,
    input  mipsPkg::hazardCtrlT ctrl,
    input  mipsPkg::ifIdT       ifId,
    input  mipsPkg::memWbT      memWb,
    output mipsPkg::idExT       idEx
);

    mipsPkg::wordT  regs [32];
    mipsPkg::instrT instr;
    mipsPkg::idExT  idExNext;

    // ------------------------------------------------------------------
    // Register file
    // ------------------------------------------------------------------
    always_ff @(posedge CLK) begin
        if (memWb.regWrite && memWb.dest != 5'd0) begin
            regs[memWb.dest] <= memWb.result;
        end
    end

    // r0 reads zero and a write in this cycle passes straight through
    function automatic mipsPkg::wordT readReg(mipsPkg::regAddrT addr);
        if (addr == 5'd0) begin
            return 32'h0;
        end else if (memWb.regWrite && memWb.dest == addr) begin
            return memWb.result;
        end
        return regs[addr];
    endfunction

    // ------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------
    assign instr = ifId.instr;

    always_comb begin
        idExNext               = '0;
        idExNext.valid         = ifId.valid;
        idExNext.pc            = ifId.pc;
        idExNext.rs            = instr.r.rs;
        idExNext.rt            = instr.i.rt;
        idExNext.dest          = instr.r.rd;
        idExNext.opA           = readReg(instr.r.rs);
        idExNext.opB           = readReg(instr.i.rt);
        idExNext.imm           = {{16{instr.i.imm[15]}}, instr.i.imm};
        idExNext.shamt         = instr.r.shamt;
        idExNext.aluOp         = mipsPkg::aluAdd;
        idExNext.branchOffset  = {{14{instr.i.imm[15]}}, instr.i.imm, 2'b00};

        case (instr.r.opcode)
            mipsPkg::opSpecial: begin
                idExNext.regWrite = 1'b1;
                case (instr.r.funct)
                    mipsPkg::functAddu: idExNext.aluOp = mipsPkg::aluAdd;
                    mipsPkg::functSubu: idExNext.aluOp = mipsPkg::aluSub;
                    mipsPkg::functAnd:  idExNext.aluOp = mipsPkg::aluAnd;
                    mipsPkg::functOr:   idExNext.aluOp = mipsPkg::aluOr;
                    mipsPkg::functSlt:  idExNext.aluOp = mipsPkg::aluSlt;
                    mipsPkg::functSll:  idExNext.aluOp = mipsPkg::aluSll;
                    default:            idExNext.regWrite = 1'b0;
                endcase
            end
            mipsPkg::opAddiu: begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.dest     = instr.i.rt;
            end
            mipsPkg::opOri: begin
                // Logical immediate is zero-extended
                idExNext.imm      = {16'h0, instr.i.imm};
                idExNext.aluOp    = mipsPkg::aluOr;
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.dest     = instr.i.rt;
            end
            mipsPkg::opLui: begin
                idExNext.aluOp    = mipsPkg::aluLui;
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.dest     = instr.i.rt;
            end
            mipsPkg::opLw: begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
                idExNext.dest     = instr.i.rt;
            end
            mipsPkg::opSw: begin
                idExNext.useImm   = 1'b1;
                idExNext.memWrite = 1'b1;
            end
            mipsPkg::opBeq: begin
                idExNext.isBranch      = 1'b1;
                idExNext.branchOnEqual = 1'b1;
            end
            mipsPkg::opBne: idExNext.isBranch = 1'b1;
            default: ;
        endcase
    end

    // ID/EX takes an empty slot on stall or flush
    always_ff @(posedge CLK) begin
        if (!rstN || ctrl.stall || ctrl.flush || !ifId.valid) begin
            idEx.valid    <= 1'b0;
            idEx.regWrite <= 1'b0;
            idEx.memRead  <= 1'b0;
            idEx.memWrite <= 1'b0;
            idEx.isBranch <= 1'b0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

//--- design/hazardControl.sv
`timescale 1ns/1ns

module hazardControl (
    input  mipsPkg::ifIdT       ifId,
    input  mipsPkg::idExT       idEx,
    input  mipsPkg::exMemT      exMem,
    input  mipsPkg::memWbT      memWb,
    output mipsPkg::hazardCtrlT ctrl
);

    // Loads are excluded from EX/MEM forwarding because the load-use
    // stall moves them to MEM/WB before the consumer reaches EX
    function automatic mipsPkg::fwdSelT fwdFor(mipsPkg::regAddrT src);
        if (src != 5'd0 && exMem.valid && exMem.regWrite && !exMem.memRead
                && exMem.dest == src) begin
            return mipsPkg::fwdExMem;
        end else if (src != 5'd0 && memWb.regWrite && memWb.dest == src) begin
            return mipsPkg::fwdMemWb;
        end
        return mipsPkg::fwdReg;
    endfunction

    always_comb begin
        ctrl.stall = ifId.valid && idEx.memRead && idEx.dest != 5'd0
                     && (idEx.dest == ifId.instr.r.rs || idEx.dest == ifId.instr.i.rt);

        // Branch resolved taken in MEM squashes the three younger slots
        ctrl.flush = exMem.valid && exMem.branchTaken;

        ctrl.fwdA = fwdFor(idEx.rs);
        ctrl.fwdB = fwdFor(idEx.rt);
    end

endmodule

//--- design/executeStage.sv
`timescale 1ns/1ns

module executeStage (
    input  logic                CLK,
    input  logic                rstN,
    input  mipsPkg::hazardCtrlT ctrl,
    input  mipsPkg::idExT       idEx,
    output mipsPkg::exMemT      exMem,
    input  mipsPkg::memWbT      memWb
);

    mipsPkg::wordT opA;
    mipsPkg::wordT opB;
    mipsPkg::wordT srcB;
    mipsPkg::wordT result;
    mipsPkg::wordT target;
    logic          taken;

    function automatic mipsPkg::wordT pickOperand(mipsPkg::fwdSelT sel,
                                                  mipsPkg::wordT regVal);
        case (sel)
            mipsPkg::fwdExMem: return exMem.aluResult;
            mipsPkg::fwdMemWb: return memWb.result;
            default:           return regVal;
        endcase
    endfunction

    // ------------------------------------------------------------------
    // ALU and branch compare
    // ------------------------------------------------------------------
    always_comb begin
        opA  = pickOperand(ctrl.fwdA, idEx.opA);
        opB  = pickOperand(ctrl.fwdB, idEx.opB);
        srcB = idEx.useImm ? idEx.imm : opB;

        case (idEx.aluOp)
            mipsPkg::aluSub: result = opA - srcB;
            mipsPkg::aluAnd: result = opA & srcB;
            mipsPkg::aluOr:  result = opA | srcB;
            mipsPkg::aluSlt: result = {31'h0, $signed(opA) < $signed(srcB)};
            mipsPkg::aluSll: result = opB << idEx.shamt;
            mipsPkg::aluLui: result = {srcB[15:0], 16'h0};
            default:         result = opA + srcB;
        endcase

        taken = idEx.isBranch && ((opA == opB) == idEx.branchOnEqual);
    end

    assign target = idEx.pc + 32'd4 + idEx.branchOffset;

    // EX/MEM
    always_ff @(posedge CLK) begin
        if (!rstN || ctrl.flush || !idEx.valid) begin
            exMem.valid       <= 1'b0;
            exMem.regWrite    <= 1'b0;
            exMem.memRead     <= 1'b0;
            exMem.memWrite    <= 1'b0;
            exMem.branchTaken <= 1'b0;
        end else begin
            exMem.valid        <= 1'b1;
            exMem.aluResult    <= result;
            exMem.storeData    <= opB;
            exMem.dest         <= idEx.dest;
            exMem.regWrite     <= idEx.regWrite;
            exMem.memRead      <= idEx.memRead;
            exMem.memWrite     <= idEx.memWrite;
            exMem.branchTaken  <= taken;
            exMem.branchTarget <= target;
        end
    end

endmodule

//--- design/memoryStage.sv
`timescale 1ns/1ns

module memoryStage (
    input  logic             CLK,
    input  logic             rstN,
    input  mipsPkg::exMemT   exMem,
    input  mipsPkg::wordT    readData,
    output mipsPkg::dataReqT dataReq,
    output logic             redirect,
    output mipsPkg::wordT    redirectPc,
    output mipsPkg::memWbT   memWb
);

    // One strobe per memory instruction while it sits in EX/MEM
    always_comb begin
        dataReq.address   = exMem.aluResult;
        dataReq.writeData = exMem.storeData;
        dataReq.read      = exMem.valid && exMem.memRead;
        dataReq.write     = exMem.valid && exMem.memWrite;
    end

    assign redirect   = exMem.valid && exMem.branchTaken;
    assign redirectPc = exMem.branchTarget;

    // MEM/WB
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            memWb.regWrite <= 1'b0;
        end else begin
            memWb.dest     <= exMem.dest;
            memWb.regWrite <= exMem.valid && exMem.regWrite;
            memWb.result   <= exMem.memRead ? readData : exMem.aluResult;
        end
    end

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ns

module mipsCore #(
    parameter mipsPkg::wordT RESET_PC = 32'h0000_0000
) (
    input  logic             CLK,
    input  logic             rstN,
    input  mipsPkg::instrT   instrIn,
    input  mipsPkg::wordT    readData,
    output mipsPkg::wordT    instrAddr,
    output mipsPkg::dataReqT dataReq
);

    mipsPkg::ifIdT       ifId;
    mipsPkg::idExT       idEx;
    mipsPkg::exMemT      exMem;
    mipsPkg::memWbT      memWb;
    mipsPkg::hazardCtrlT ctrl;
    logic                redirect;
    mipsPkg::wordT       redirectPc;

    // ------------------------------------------------------------------
    // Pipeline stages
    // ------------------------------------------------------------------
    fetchStage #(
        .RESET_PC(RESET_PC)
    ) i_fetchStage (
        .CLK       (CLK),
        .rstN      (rstN),
        .ctrl      (ctrl),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .instrIn   (instrIn),
        .instrAddr (instrAddr),
        .ifId      (ifId)
    );

    decodeStage i_decodeStage (
        .CLK  (CLK),
        .rstN (rstN),
        .ctrl (ctrl),
        .ifId (ifId),
        .memWb(memWb),
        .idEx (idEx)
    );

    executeStage i_executeStage (
        .CLK  (CLK),
        .rstN (rstN),
        .ctrl (ctrl),
        .idEx (idEx),
        .exMem(exMem),
        .memWb(memWb)
    );

    memoryStage i_memoryStage (
        .CLK       (CLK),
        .rstN      (rstN),
        .exMem     (exMem),
        .readData  (readData),
        .dataReq   (dataReq),
        .redirect  (redirect),
        .redirectPc(redirectPc),
        .memWb     (memWb)
    );

    // Stall, flush and forwarding selects
    hazardControl i_hazardControl (
        .ifId (ifId),
        .idEx (idEx),
        .exMem(exMem),
        .memWb(memWb),
        .ctrl (ctrl)
    );

endmodule

//--- sim/mipsTb.sv
`timescale 1ns/1ns

module mipsTb;

    localparam mipsPkg::wordT resetPc      = 32'h0000_0000;
    localparam mipsPkg::wordT sentinelAddr = 32'h0000_03fc;
    localparam int bodyStart     = 31;
    localparam int bodyLen       = 200;
    localparam int timeoutCycles = 5000;

    logic             CLK;
    logic             rstN;
    mipsPkg::instrT   instrIn;
    mipsPkg::wordT    readData;
    mipsPkg::wordT    instrAddr;
    mipsPkg::dataReqT dataReq;

    logic [31:0] imem [512];
    logic [31:0] dmem [256];
    logic [31:0] modelMem [256];
    logic [31:0] expAddr [$];
    logic [31:0] expData [$];

    integer seed         = 32'he3f9;
    int     errors       = 0;
    int     cyclesOut    = 0;
    logic   sentinelSeen = 1'b0;

    mipsCore #(
        .RESET_PC(resetPc)
    ) i_mipsCore (
        .CLK      (CLK),
        .rstN     (rstN),
        .instrIn  (instrIn),
        .readData (readData),
        .instrAddr(instrAddr),
        .dataReq  (dataReq)
    );

    // Both memories answer in the same cycle
    assign instrIn  = imem[instrAddr[10:2]];
    // Data memory returns the inverted word unless read is high
    assign readData = dataReq.read ? dmem[dataReq.address[9:2]]
                                   : ~dmem[dataReq.address[9:2]];

    initial begin
        CLK = 1'b0;
        forever #20 CLK = ~CLK;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("ERR %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Program generation
    // ------------------------------------------------------------------
    function automatic int unsigned randBelow(int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [31:0] rWord(logic [5:0] funct, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd, logic [4:0] shamt);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [31:0] iWord(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] aluInstr(logic [4:0] rd, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        case (randBelow(9))
            0:       return rWord(mipsPkg::functAddu, rs, rt, rd, 5'd0);
            1:       return rWord(mipsPkg::functSubu, rs, rt, rd, 5'd0);
            2:       return rWord(mipsPkg::functAnd, rs, rt, rd, 5'd0);
            3:       return rWord(mipsPkg::functOr, rs, rt, rd, 5'd0);
            4:       return rWord(mipsPkg::functSlt, rs, rt, rd, 5'd0);
            5:       return rWord(mipsPkg::functSll, 5'd0, rt, rd, imm[4:0]);
            6:       return iWord(mipsPkg::opAddiu, rs, rd, imm);
            7:       return iWord(mipsPkg::opOri, rs, rd, imm);
            default: return iWord(mipsPkg::opLui, 5'd0, rd, imm);
        endcase
    endfunction

    task automatic buildProgram();
        int          idx;
        int          room;
        int          off;
        logic [4:0]  rd;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        logic [15:0] slot;
        for (int i = 0; i < 512; i++) begin
            imem[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0000;
        end
        // Prologue gives every register a known value
        for (int r = 1; r < 32; r++) begin
            imem[r - 1] = iWord(mipsPkg::opAddiu, 5'd0, 5'(r), 16'($random(seed)));
        end
        // Body uses r0..r7 only so hazards come often
        for (idx = bodyStart; idx < bodyStart + bodyLen; idx++) begin
            rd   = 5'(randBelow(8));
            rs   = 5'(randBelow(8));
            rt   = 5'(randBelow(8));
            imm  = 16'($random(seed));
            slot = 16'h0100 + 16'(4 * randBelow(64));
            room = bodyStart + bodyLen - idx - 1;
            off  = 1 + randBelow(3);
            if (off > room) begin
                off = room;
            end
            case (randBelow(10))
                0, 1, 2, 3, 4, 5: imem[idx] = aluInstr(rd, rs, rt, imm);
                6: imem[idx] = iWord(mipsPkg::opLw, 5'd0, rt, slot);
                7: imem[idx] = iWord(mipsPkg::opSw, 5'd0, rt, slot);
                default: imem[idx] = iWord(randBelow(2) ? mipsPkg::opBeq : mipsPkg::opBne,
                                           rs, rt, 16'(off));
            endcase
        end
        // Epilogue dumps r1..r31 and then stores r0 to the sentinel
        for (int r = 1; r < 32; r++) begin
            imem[idx + r - 1] = iWord(mipsPkg::opSw, 5'd0, 5'(r), 16'(32'h200 + 4 * r));
        end
        imem[idx + 31] = iWord(mipsPkg::opSw, 5'd0, 5'd0, sentinelAddr[15:0]);
    endtask

    // ------------------------------------------------------------------
    // Reference model running one instruction at a time
    // ------------------------------------------------------------------
    task automatic runModel();
        logic [31:0] regs [32];
        logic [31:0] pc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] addr;
        logic        stop;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'h0;
        end
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = dmem[i];
        end
        pc   = resetPc;
        stop = 1'b0;
        for (int steps = 0; steps < 20000 && !stop; steps++) begin
            w    = imem[pc[10:2]];
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            simm = {{16{w[15]}}, w[15:0]};
            addr = a + simm;
            pc   = pc + 32'd4;
            case (w[31:26])
                mipsPkg::opSpecial: begin
                    case (w[5:0])
                        mipsPkg::functAddu: regs[w[15:11]] = a + b;
                        mipsPkg::functSubu: regs[w[15:11]] = a - b;
                        mipsPkg::functAnd:  regs[w[15:11]] = a & b;
                        mipsPkg::functOr:   regs[w[15:11]] = a | b;
                        mipsPkg::functSlt:  regs[w[15:11]] = {31'h0, $signed(a) < $signed(b)};
                        mipsPkg::functSll:  regs[w[15:11]] = b << w[10:6];
                        default: ;
                    endcase
                end
                mipsPkg::opAddiu: regs[w[20:16]] = addr;
                mipsPkg::opOri:   regs[w[20:16]] = a | {16'h0, w[15:0]};
                mipsPkg::opLui:   regs[w[20:16]] = {w[15:0], 16'h0};
                mipsPkg::opLw:    regs[w[20:16]] = modelMem[addr[9:2]];
                mipsPkg::opSw: begin
                    modelMem[addr[9:2]] = b;
                    expAddr.push_back(addr);
                    expData.push_back(b);
                    stop = (addr == sentinelAddr);
                end
                mipsPkg::opBeq: if (a == b) pc = pc + (simm << 2);
                mipsPkg::opBne: if (a != b) pc = pc + (simm << 2);
                default: ;
            endcase
            regs[0] = 32'h0;
        end
    endtask

    // ------------------------------------------------------------------
    // Data port monitor sampled on the falling edge
    // ------------------------------------------------------------------
    always @(negedge CLK) begin
        if (rstN) begin
            // Nothing can reach EX/MEM in the first three cycles
            if (cyclesOut < 3) begin
                checkValue("strobes after reset", 32'd0, {30'd0, dataReq.read, dataReq.write});
            end
            cyclesOut++;
            if (dataReq.write) begin
                if (expAddr.size() == 0) begin
                    errors++;
                    $display("Store to %h arrived after the model ran out of stores",
                             dataReq.address);
                end else begin
                    checkValue("store address", expAddr.pop_front(), dataReq.address);
                    checkValue("store data", expData.pop_front(), dataReq.writeData);
                end
                dmem[dataReq.address[9:2]] = dataReq.writeData;
                if (dataReq.address == sentinelAddr) begin
                    sentinelSeen = 1'b1;
                end
            end
        end
    end

    initial begin
        rstN = 1'b0;
        buildProgram();
        runModel();
        repeat (10) @(posedge CLK);
        #2 rstN = 1'b1;
        checkValue("reset pc", resetPc, instrAddr);
        for (int c = 0; c < timeoutCycles && !sentinelSeen; c++) begin
            @(posedge CLK);
        end
        if (!sentinelSeen) begin
            errors++;
            $display("Timeout, no sentinel store within %0d cycles", timeoutCycles);
        end
        @(posedge CLK);
        checkValue("stores left in model", 32'd0, expAddr.size());
        for (int i = 0; i < 256; i++) begin
            checkValue($sformatf("data word %0d", i), modelMem[i], dmem[i]);
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
design/mipsPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardControl.sv
design/executeStage.sv
design/memoryStage.sv
design/mipsCore.sv
sim/mipsTb.sv

//--- Makefile
TOP = mipsTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal --top-module $(TOP) -f filelist.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
